// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;               // Immediate layout assumes 32-bit words

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [1:0]      opa_sel_t;     // First ALU operand source
    typedef logic [1:0]      wb_sel_t;      // Write-back source

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam opa_sel_t OPA_REG  = 2'd0;
    localparam opa_sel_t OPA_ZERO = 2'd1;
    localparam opa_sel_t OPA_PC   = 2'd2;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        opa_sel_t op_a_sel;
        logic     op_b_imm;
        wb_sel_t  wb_sel;
        logic     branch;
        logic     branch_ne;
        alu_op_e  alu_op;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     reg_we;
        reg_idx_t rd;
        word_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: verilog/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];                  // RV32I shifts use five bits only

    always_comb begin
        unique case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, a < b};
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            PASS_B:  result = b;            // Lets lui bypass the first operand
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);           // Branch compare after SUB

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  word_t    instr,
    output ctrl_t    ctrl,
    output word_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_e    alu_fn;                     // Operation selected by funct3 and bit 30

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // All immediate formats are sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU control shared by the register and immediate forms
    always_comb begin
        unique case (funct3)
            3'b000:  alu_fn = (opcode == OPC_OP && bit30) ? SUB : ADD;  // No subi exists
            3'b001:  alu_fn = SLL;
            3'b010:  alu_fn = SLT;
            3'b011:  alu_fn = SLTU;
            3'b100:  alu_fn = XOR;
            3'b101:  alu_fn = bit30 ? SRA : SRL;
            3'b110:  alu_fn = OR;
            default: alu_fn = AND;
        endcase
    end

    always_comb begin
        ctrl          = '0;                 // Unknown encodings retire as a no-op
        ctrl.alu_op   = ADD;
        ctrl.op_a_sel = OPA_REG;
        ctrl.wb_sel   = WB_ALU;
        imm           = imm_i;
        unique case (opcode)
            OPC_OP: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_fn;
            end
            OPC_OP_IMM: begin
                ctrl.reg_we   = 1'b1;
                ctrl.op_b_imm = 1'b1;
                ctrl.alu_op   = alu_fn;     // Shift amount sits in imm_i[4:0]
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin // Only lw is supported
                    ctrl.reg_we   = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    ctrl.wb_sel   = WB_MEM;
                end
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b010) begin // Only sw is supported
                    ctrl.mem_we   = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3[2:1] == 2'b00) begin     // beq and bne
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = SUB;           // Equal operands give a zero result
                end
            end
            OPC_LUI: begin
                imm           = imm_u;
                ctrl.reg_we   = 1'b1;
                ctrl.op_b_imm = 1'b1;
                ctrl.alu_op   = PASS_B;
            end
            OPC_AUIPC: begin
                imm           = imm_u;
                ctrl.reg_we   = 1'b1;
                ctrl.op_a_sel = OPA_PC;
                ctrl.op_b_imm = 1'b1;
            end
            OPC_JAL: begin
                // An always-taken branch, since zero AND imm is always zero
                imm           = imm_j;
                ctrl.reg_we   = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                ctrl.branch   = 1'b1;
                ctrl.op_a_sel = OPA_ZERO;
                ctrl.op_b_imm = 1'b1;
                ctrl.alu_op   = AND;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert (!(ctrl.reg_we && ctrl.mem_we))
            else $error("decoder drives register write and store together");
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic     CLK,
    input  logic     RESET_N,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [1:31];                     // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // A write aimed at x0 must leave it reading as zero afterwards
    a_x0_stays_zero: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        (we && rd == '0) |=> (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0)
    ) else $error("x0 read back nonzero after a write to it");

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter int ADDR_WIDTH = 10           // Word address width from 4 to 30
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    output logic [ADDR_WIDTH-1:0] instr_addr,
    input  word_t                 instr,
    output logic [ADDR_WIDTH-1:0] data_addr,
    input  word_t                 data_rdata,
    output word_t                 data_wdata,
    output logic                  data_we,
    output retire_t               retire
);

    word_t    pc;
    word_t    pc_plus4;
    word_t    pc_target;
    word_t    next_pc;
    ctrl_t    ctrl;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;
    logic     alu_zero;
    logic     take_branch;
    logic     reg_we;
    word_t    wb_data;

    rv_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    rv_regfile u_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (reg_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        unique case (ctrl.op_a_sel)
            OPA_ZERO: op_a = '0;
            OPA_PC:   op_a = pc;            // auipc
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl.op_b_imm ? imm : rs2_data;

    rv_alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // One adder serves both the branch target and the jal target
    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + imm;
    assign take_branch = ctrl.branch && (alu_zero != ctrl.branch_ne);
    assign next_pc     = take_branch ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        unique case (ctrl.wb_sel)
            WB_MEM:  wb_data = data_rdata;
            WB_PC4:  wb_data = pc_plus4;    // Link value of jal
            default: wb_data = alu_result;
        endcase
    end

    assign reg_we = ctrl.reg_we & RESET_N;

    assign instr_addr = pc[ADDR_WIDTH+1:2];
    assign data_addr  = alu_result[ADDR_WIDTH+1:2];
    assign data_wdata = rs2_data;
    assign data_we    = ctrl.mem_we & RESET_N;  // No stores while held in reset

    assign retire.valid  = RESET_N;
    assign retire.pc     = pc;
    assign retire.reg_we = reg_we;
    assign retire.rd     = rd;
    assign retire.wdata  = wb_data;

    // A retiring instruction either stores or writes a register, never both
    a_store_or_write: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        !(data_we && retire.reg_we)
    ) else $error("store and register write retired in the same cycle");

endmodule

`default_nettype wire

// File: verification/rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// Architectural state of the reference model
word_t model_regs [0:31];
word_t model_pc;
word_t model_mem [0:1023];
logic  model_store_we;                      // Store expected in the current step
word_t model_store_addr;
word_t model_store_data;

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
        model_mem[i] = fill_word(i);
    end
    model_pc = '0;
endtask

// RV32I integer operations selected by funct3 where alt picks sub and sra
function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t res;
    case (f3)
        3'd0:    res = alt ? a - b : a + b;
        3'd1:    res = a << b[4:0];
        3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    res = (a < b) ? 32'd1 : 32'd0;
        3'd4:    res = a ^ b;
        3'd5:    res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

// Executes one instruction on the model and returns what should retire
function automatic retire_t step_model(input word_t ins);
    retire_t    res;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      next_pc;
    f3               = ins[14:12];
    a                = model_regs[ins[19:15]];
    b                = model_regs[ins[24:20]];
    res              = '0;
    res.valid        = 1'b1;
    res.pc           = model_pc;
    res.rd           = ins[11:7];
    next_pc          = model_pc + 32'd4;
    model_store_we   = 1'b0;
    model_store_addr = '0;
    model_store_data = '0;
    case (ins[6:0])
        OPC_OP: begin
            res.reg_we = 1'b1;
            res.wdata  = model_alu(f3, ins[30], a, b);
        end
        OPC_OP_IMM: begin
            res.reg_we = 1'b1;              // Only srai uses bit 30 here
            res.wdata  = model_alu(f3, f3 == 3'd5 && ins[30], a, word_t'($signed(ins[31:20])));
        end
        OPC_LOAD: begin
            addr       = a + word_t'($signed(ins[31:20]));
            res.reg_we = 1'b1;
            res.wdata  = model_mem[addr[11:2]];
        end
        OPC_STORE: begin
            addr                  = a + word_t'($signed({ins[31:25], ins[11:7]}));
            model_store_we        = 1'b1;
            model_store_addr      = addr;
            model_store_data      = b;
            model_mem[addr[11:2]] = b;
        end
        OPC_BRANCH: begin
            if ((a == b) != ins[12]) begin  // funct3 bit 0 turns beq into bne
                next_pc = model_pc + word_t'($signed({ins[31], ins[7], ins[30:25],
                                                      ins[11:8], 1'b0}));
            end
        end
        OPC_LUI: begin
            res.reg_we = 1'b1;
            res.wdata  = {ins[31:12], 12'h000};
        end
        OPC_AUIPC: begin
            res.reg_we = 1'b1;
            res.wdata  = model_pc + {ins[31:12], 12'h000};
        end
        OPC_JAL: begin
            res.reg_we = 1'b1;
            res.wdata  = model_pc + 32'd4;
            next_pc    = model_pc + word_t'($signed({ins[31], ins[19:12], ins[20],
                                                     ins[30:21], 1'b0}));
        end
        default: begin
        end
    endcase
    if (res.reg_we && res.rd != 5'd0) begin
        model_regs[res.rd] = res.wdata;
    end
    model_pc = next_pc;
    return res;
endfunction

`endif

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int    ADDR_WIDTH = 10;
    localparam int    MEM_WORDS  = 1024;
    localparam int    PROG_LEN   = 300;
    localparam int    MAX_CYCLES = PROG_LEN + 100;  // One cycle per instruction plus reset and slack
    localparam word_t FINAL_PC   = word_t'((PROG_LEN - 1) * 4);

    logic                  CLK;
    logic                  RESET_N;
    logic [ADDR_WIDTH-1:0] instr_addr;
    word_t                 instr;
    logic [ADDR_WIDTH-1:0] data_addr;
    word_t                 data_rdata;
    word_t                 data_wdata;
    logic                  data_we;
    retire_t               retire;

    word_t imem [0:MEM_WORDS-1];
    word_t dmem [0:MEM_WORDS-1];
    int    seed = 6699;
    int    cycle_count;

    rv_core #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_rdata (data_rdata),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .retire     (retire)
    );

    assign instr      = imem[instr_addr];   // Both memories answer within the cycle
    assign data_rdata = dmem[data_addr];

    always @(posedge CLK) begin
        if (data_we) begin
            dmem[data_addr] <= data_wdata;
        end
    end

    function automatic word_t fill_word(input int i);
        return {~i[15:0], i[15:0]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic word_t r_type(input reg_idx_t rd, rs1, rs2,
                                     input logic [2:0] f3, input logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input reg_idx_t rd, rs1, input logic [2:0] f3,
                                     input logic [11:0] imm, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input reg_idx_t rs1, rs2, input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input reg_idx_t rs1, rs2, input logic [2:0] f3,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input reg_idx_t rd, input logic [19:0] imm,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    `include "rv_core_model.svh"

    task automatic build_program();
        int          r;
        int          words;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = i_type(5'd0, 5'd0, 3'd0, 12'(i), OPC_OP_IMM);  // Unreached no-ops
            dmem[i] = fill_word(i);
        end
        imem[0] = i_type(5'd1, 5'd0, 3'd0, 12'd256, OPC_OP_IMM);     // Data window bases
        imem[1] = i_type(5'd2, 5'd0, 3'd0, 12'd512, OPC_OP_IMM);
        for (int i = 2; i < 7; i++) begin
            imem[i] = i_type(reg_idx_t'(i + 1), 5'd0, 3'd0, 12'(pick(4096)), OPC_OP_IMM);
        end
        imem[7] = i_type(5'd0, 5'd0, 3'd0, 12'd77, OPC_OP_IMM);      // Must not stick in x0
        for (int i = 8; i < PROG_LEN - 1; i++) begin
            r     = pick(6);
            rd    = (r == 0) ? 5'd0 : reg_idx_t'(r + 2);              // x1 and x2 stay fixed
            rs1   = reg_idx_t'(pick(8));
            rs2   = reg_idx_t'(pick(8));
            f3    = 3'(pick(8));
            words = 1 + pick(4);
            if (words > PROG_LEN - 1 - i) begin
                words = PROG_LEN - 1 - i;   // Never jump past the final instruction
            end
            case (pick(10))
                0, 1: begin
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'b0100000 : 7'b0;
                    imem[i] = r_type(rd, rs1, rs2, f3, f7);
                end
                2, 3: begin
                    if (f3 == 3'd1) begin
                        imm12 = {7'b0, 5'(pick(32))};
                    end else if (f3 == 3'd5) begin
                        imm12 = {(pick(2) == 1) ? 7'b0100000 : 7'b0, 5'(pick(32))};
                    end else begin
                        imm12 = 12'(pick(4096));
                    end
                    imem[i] = i_type(rd, rs1, f3, imm12, OPC_OP_IMM);
                end
                4: imem[i] = i_type(rd, reg_idx_t'(1 + pick(2)), 3'b010, 12'(pick(64) * 4),
                                    OPC_LOAD);
                5: imem[i] = s_type(reg_idx_t'(1 + pick(2)), rs2, 12'(pick(64) * 4));
                6, 7: begin
                    if (pick(4) == 0) begin
                        rs2 = rs1;          // Equal operands so beq is taken now and then
                    end
                    imem[i] = b_type(rs1, rs2, 3'(pick(2)), 13'(words * 4));
                end
                8: imem[i] = u_type(rd, 20'(pick(1 << 20)), (pick(2) == 1) ? OPC_LUI : OPC_AUIPC);
                default: imem[i] = j_type(rd, 21'(words * 4));
            endcase
        end
        imem[PROG_LEN-1] = j_type(5'd0, 21'd0);                        // Jump to itself
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        word_t boot_word;
        RESET_N = 1'b0;
        build_program();
        reset_model();
        boot_word = imem[0];
        imem[0]   = s_type(5'd1, 5'd2, 12'd0);  // A store fetched in reset must not reach memory
        repeat (2) @(negedge CLK);
        imem[0] = boot_word;                     // Register writes are masked in the last cycle
        @(negedge CLK);
        RESET_N <= 1'b1;
    end

    initial begin : compare_proc
        retire_t expected;
        logic    at_end;
        at_end = 1'b0;
        while (!at_end) begin
            @(negedge CLK);
            #1;                             // Let the reset release settle
            if (!RESET_N) begin
                check_value("reset data_we", word_t'(1'b0), word_t'(data_we));
                check_value("reset retire.valid", word_t'(1'b0), word_t'(retire.valid));
                check_value("reset retire.reg_we", word_t'(1'b0), word_t'(retire.reg_we));
            end else begin
                expected = step_model(imem[model_pc[ADDR_WIDTH+1:2]]);
                check_value("instr_addr", word_t'(expected.pc[ADDR_WIDTH+1:2]),
                            word_t'(instr_addr));
                check_value("retire.valid", word_t'(1'b1), word_t'(retire.valid));
                check_value("retire.pc", expected.pc, retire.pc);
                check_value("retire.reg_we", word_t'(expected.reg_we), word_t'(retire.reg_we));
                if (expected.reg_we) begin
                    check_value("retire.rd", word_t'(expected.rd), word_t'(retire.rd));
                    check_value("retire.wdata", expected.wdata, retire.wdata);
                end
                check_value("data_we", word_t'(model_store_we), word_t'(data_we));
                if (model_store_we) begin
                    check_value("data_addr", word_t'(model_store_addr[ADDR_WIDTH+1:2]),
                                word_t'(data_addr));
                    check_value("data_wdata", model_store_data, data_wdata);
                end
                at_end = (expected.pc == FINAL_PC);
            end
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout after %0d cycles without reaching the final jump", MAX_CYCLES);
        $display("TB FAILED");
        $fatal(1, "simulation ran out of cycles");
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+verification
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile rv_core_tb with Verilator and run it; the run's exit status is the result
set -u
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 \
        --top-module rv_core_tb \
        -f rv_core.f \
        -o rv_core_sim &&
    ./obj_dir/rv_core_sim ||
    { echo "rv_core simulation did not complete cleanly"; exit 1; }
